// File: source/pinballPkg.sv
`default_nettype none

package pinballPkg;

	localparam logic [7:0] COLOR_DEFAULT = 8'hFF; // white menu text
	localparam logic [7:0] COLOR_RED = 8'hE0; // RGB332 red marks the chosen type

	typedef enum logic [3:0] {
		KEY_0 = 4'd0,
		KEY_1 = 4'd1,
		KEY_2 = 4'd2,
		KEY_3 = 4'd3,
		KEY_4 = 4'd4,
		KEY_5 = 4'd5,
		KEY_6 = 4'd6,
		KEY_7 = 4'd7,
		KEY_8 = 4'd8,
		KEY_9 = 4'd9
	} keyCode_t;

	typedef enum logic [1:0] {
		SCREEN_WELCOME = 2'd0,
		SCREEN_PLAYING = 2'd1,
		SCREEN_GAMEOVER = 2'd2
	} screen_t;

	// only the keys the setup screens react to
	typedef struct packed {
		logic key2;
		logic key4;
		logic key5;
		logic key6;
		logic key8;
	} keyLevels_t;

	typedef struct packed {
		logic [3:0] playerId;
		logic flipperType; // 0 is single, 1 is dual
		logic [7:0] colorSingle;
		logic [7:0] colorDual;
	} gameSetup_t;

endpackage

`default_nettype wire

// File: source/keypadDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module keypadDecoder
	import pinballPkg::*;
(
	input wire clk,
	input wire resetN,
	input wire keyCode_t keyCode,
	input wire keyValid,
	output keyLevels_t keys
);

	keyLevels_t keysCurrent;
	keyLevels_t keysNext;

	assign keys = keysCurrent;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			keysCurrent <= '0;
		end else begin
			keysCurrent <= keysNext;
		end
	end

	always_comb begin
		keysNext = '0; // a key that is let go drops on the next edge
		if (keyValid) begin
			case (keyCode)
				KEY_2: begin
					keysNext.key2 = 1'b1;
				end
				KEY_4: begin
					keysNext.key4 = 1'b1;
				end
				KEY_5: begin
					keysNext.key5 = 1'b1;
				end
				KEY_6: begin
					keysNext.key6 = 1'b1;
				end
				KEY_8: begin
					keysNext.key8 = 1'b1;
				end
				default: begin // other digits have no meaning here
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/secondTimer.sv
`timescale 1ns/1ps
`default_nettype none

module secondTimer #(
	parameter int CLOCKS_PER_SEC = 50_000_000
) (
	input wire clk,
	input wire resetN,
	output logic oneSecPulse
);

	localparam int CNT_W = (CLOCKS_PER_SEC > 1) ? $clog2(CLOCKS_PER_SEC) : 1;
	localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CLOCKS_PER_SEC - 1);

	logic [CNT_W-1:0] clockCount;
	logic wrap;

	assign wrap = (clockCount == LAST_COUNT);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			clockCount <= '0;
			oneSecPulse <= 1'b0;
		end else begin
			oneSecPulse <= wrap; // high for the cycle after the last count
			if (wrap) begin
				clockCount <= '0;
			end else begin
				clockCount <= clockCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/screenSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module screenSequencer
	import pinballPkg::*;
#(
	parameter int GAME_OVER_SECONDS = 3
) (
	input wire clk,
	input wire resetN,
	input wire keyLevels_t keys,
	input wire gameOver,
	input wire oneSecPulse,
	output screen_t screen
);

	localparam int SEC_W = $clog2(GAME_OVER_SECONDS + 1);
	localparam logic [SEC_W-1:0] SEC_LOAD = SEC_W'(GAME_OVER_SECONDS);

	screen_t stateCurrent;
	screen_t stateNext;
	logic [SEC_W-1:0] secondsLeftCurrent;
	logic [SEC_W-1:0] secondsLeftNext;

	assign screen = stateCurrent;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			stateCurrent <= SCREEN_WELCOME;
			secondsLeftCurrent <= '0;
		end else begin
			stateCurrent <= stateNext;
			secondsLeftCurrent <= secondsLeftNext;
		end
	end

	always_comb begin
		stateNext = stateCurrent;
		secondsLeftNext = secondsLeftCurrent;
		case (stateCurrent)
			SCREEN_WELCOME: begin
				if (keys.key5) begin
					stateNext = SCREEN_PLAYING;
				end
			end
			SCREEN_PLAYING: begin
				if (gameOver) begin
					stateNext = SCREEN_GAMEOVER;
					secondsLeftNext = SEC_LOAD;
				end
			end
			SCREEN_GAMEOVER: begin
				// the first pulse may come at any phase, so the shown time is not exact
				if (oneSecPulse) begin
					if (secondsLeftCurrent <= 1) begin
						stateNext = SCREEN_WELCOME;
						secondsLeftNext = '0;
					end else begin
						secondsLeftNext = secondsLeftCurrent - 1'b1;
					end
				end
			end
			default: begin
				stateNext = SCREEN_WELCOME; // recover from the unused code
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/welcomeController.sv
`timescale 1ns/1ps
`default_nettype none

module welcomeController
	import pinballPkg::*;
#(
	parameter int MAX_PLAYERS = 9
) (
	input wire clk,
	input wire resetN,
	input wire keyLevels_t keys,
	input wire screen_t screen,
	input wire oneSecPulse,
	output gameSetup_t setup
);

	localparam logic [3:0] PLAYER_MAX = 4'(MAX_PLAYERS);
	localparam logic [3:0] PLAYER_MIN = 4'd1;

	logic onWelcome;
	logic [3:0] playerIdCurrent;
	logic [3:0] playerIdNext;
	logic lockoutCurrent;
	logic lockoutNext;
	logic flipperTypeCurrent;
	logic flipperTypeNext;
	logic [7:0] colorSingleCurrent;
	logic [7:0] colorSingleNext;
	logic [7:0] colorDualCurrent;
	logic [7:0] colorDualNext;

	assign onWelcome = (screen == SCREEN_WELCOME);

	assign setup = '{
		playerId: playerIdCurrent,
		flipperType: flipperTypeCurrent,
		colorSingle: colorSingleCurrent,
		colorDual: colorDualCurrent
	};

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			playerIdCurrent <= PLAYER_MIN;
			lockoutCurrent <= 1'b0;
			flipperTypeCurrent <= 1'b0;
			colorSingleCurrent <= COLOR_DEFAULT;
			colorDualCurrent <= COLOR_DEFAULT;
		end else begin
			playerIdCurrent <= playerIdNext;
			lockoutCurrent <= lockoutNext;
			flipperTypeCurrent <= flipperTypeNext;
			colorSingleCurrent <= colorSingleNext;
			colorDualCurrent <= colorDualNext;
		end
	end

	// one step per press, a held key steps again once per second
	always_comb begin
		playerIdNext = playerIdCurrent;
		lockoutNext = lockoutCurrent;
		if (onWelcome) begin
			if (lockoutCurrent) begin
				if (oneSecPulse) begin
					lockoutNext = 1'b0;
				end
			end else if (keys.key8) begin
				if (playerIdCurrent < PLAYER_MAX) begin
					playerIdNext = playerIdCurrent + 1'b1;
					lockoutNext = 1'b1;
				end
			end else if (keys.key2) begin
				if (playerIdCurrent > PLAYER_MIN) begin
					playerIdNext = playerIdCurrent - 1'b1;
					lockoutNext = 1'b1;
				end
			end
		end
	end

	always_comb begin
		flipperTypeNext = flipperTypeCurrent;
		if (onWelcome) begin
			if (keys.key4) begin
				flipperTypeNext = 1'b0;
			end else if (keys.key6) begin
				flipperTypeNext = 1'b1;
			end
		end
	end

	always_comb begin
		if (flipperTypeCurrent) begin
			colorSingleNext = COLOR_DEFAULT;
			colorDualNext = COLOR_RED;
		end else begin
			colorSingleNext = COLOR_RED;
			colorDualNext = COLOR_DEFAULT;
		end
	end

endmodule

`default_nettype wire

// File: source/pinballSetupTop.sv
`timescale 1ns/1ps
`default_nettype none

module pinballSetupTop
	import pinballPkg::*;
#(
	parameter int CLOCKS_PER_SEC = 50_000_000,
	parameter int GAME_OVER_SECONDS = 3,
	parameter int MAX_PLAYERS = 9
) (
	input wire clk,
	input wire resetN,
	input wire keyCode_t keyCode,
	input wire keyValid,
	input wire gameOver,
	output screen_t screen,
	output gameSetup_t setup
);

	keyLevels_t keys;
	logic oneSecPulse;

	keypadDecoder decoder (
		.clk(clk),
		.resetN(resetN),
		.keyCode(keyCode),
		.keyValid(keyValid),
		.keys(keys)
	);

	secondTimer #(
		.CLOCKS_PER_SEC(CLOCKS_PER_SEC)
	) timer (
		.clk(clk),
		.resetN(resetN),
		.oneSecPulse(oneSecPulse)
	);

	// the sequencer owns the screen, the welcome block only watches it
	screenSequencer #(
		.GAME_OVER_SECONDS(GAME_OVER_SECONDS)
	) sequencer (
		.clk(clk),
		.resetN(resetN),
		.keys(keys),
		.gameOver(gameOver),
		.oneSecPulse(oneSecPulse),
		.screen(screen)
	);

	welcomeController #(
		.MAX_PLAYERS(MAX_PLAYERS)
	) welcome (
		.clk(clk),
		.resetN(resetN),
		.keys(keys),
		.screen(screen),
		.oneSecPulse(oneSecPulse),
		.setup(setup)
	);

endmodule

`default_nettype wire

// File: testbench/pinballSetupTb.sv
`timescale 1ns/1ps
`default_nettype none

module pinballSetupTb
	import pinballPkg::*;
();

	localparam int CLOCKS_PER_SEC = 20;
	localparam int GAME_OVER_SECONDS = 2;
	localparam int MAX_PLAYERS = 9;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_PRESSES = 30;
	localparam int HOLD_CYCLES = 3 * CLOCKS_PER_SEC;
	localparam int SEED = 88319;

	logic clk;
	logic resetN;
	keyCode_t keyCode;
	logic keyValid;
	logic gameOver;
	screen_t screen;
	gameSetup_t setup;

	int errorCount;
	int checkCount;
	int modelPlayerId;
	logic modelFlipper;
	screen_t modelScreen;

	pinballSetupTop #(
		.CLOCKS_PER_SEC(CLOCKS_PER_SEC),
		.GAME_OVER_SECONDS(GAME_OVER_SECONDS),
		.MAX_PLAYERS(MAX_PLAYERS)
	) uut (
		.clk(clk),
		.resetN(resetN),
		.keyCode(keyCode),
		.keyValid(keyValid),
		.gameOver(gameOver),
		.screen(screen),
		.setup(setup)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic checkValue(input string testName, input int expected, input int actual);
		checkCount++;
		assert (actual == expected) else begin
			errorCount++;
			$display("Fail %s expected %0d actual %0d", testName, expected, actual);
		end
	endtask

	// compares screen and setup with the model at a quiet point of the clock
	task automatic checkSetup(input string testName);
		int expectedSingle;
		int expectedDual;
		@(negedge clk);
		expectedSingle = modelFlipper ? int'(COLOR_DEFAULT) : int'(COLOR_RED);
		expectedDual = modelFlipper ? int'(COLOR_RED) : int'(COLOR_DEFAULT);
		checkValue({testName, " screen"}, int'(modelScreen), int'(screen));
		checkValue({testName, " playerId"}, modelPlayerId, int'(setup.playerId));
		checkValue({testName, " flipperType"}, int'(modelFlipper), int'(setup.flipperType));
		checkValue({testName, " colorSingle"}, expectedSingle, int'(setup.colorSingle));
		checkValue({testName, " colorDual"}, expectedDual, int'(setup.colorDual));
	endtask

	function automatic void applyKeyToModel(input keyCode_t key);
		if (modelScreen == SCREEN_WELCOME) begin
			case (key)
				KEY_8: begin
					if (modelPlayerId < MAX_PLAYERS) modelPlayerId++;
				end
				KEY_2: begin
					if (modelPlayerId > 1) modelPlayerId--;
				end
				KEY_4: begin
					modelFlipper = 1'b0;
				end
				KEY_6: begin
					modelFlipper = 1'b1;
				end
				KEY_5: begin
					modelScreen = SCREEN_PLAYING;
				end
				default: begin
				end
			endcase
		end
	endfunction

	task automatic holdKey(input keyCode_t key, input int cycles);
		@(posedge clk);
		keyCode <= key;
		keyValid <= 1'b1;
		repeat (cycles) @(posedge clk);
		keyValid <= 1'b0;
	endtask

	// the key is held for two cycles and released for two seconds so that the step lockout clears
	task automatic pressKey(input keyCode_t key);
		holdKey(key, 2);
		repeat (2 * CLOCKS_PER_SEC) @(posedge clk);
		applyKeyToModel(key);
	endtask

	task automatic pulseGameOver();
		@(posedge clk);
		gameOver <= 1'b1;
		@(posedge clk);
		gameOver <= 1'b0;
	endtask

	task automatic waitForScreen(input screen_t target, input int limit, input string testName);
		int count;
		logic reached;
		count = 0;
		@(negedge clk);
		reached = (screen == target);
		while (!reached && count < limit) begin
			@(negedge clk);
			count++;
			reached = (screen == target);
		end
		checkCount++;
		assert (reached) else begin
			errorCount++;
			$display("%s: screen did not become %s within %0d cycles", testName,
				target.name(), limit);
		end
	endtask

	initial begin
		int i;
		int pick;
		int startId;
		int stepCount;
		int maxSteps;
		int offWelcomeCycles;
		keyCode_t frozenKeys[5];

		resetN = 1'b0;
		keyCode = KEY_0;
		keyValid = 1'b0;
		gameOver = 1'b0;
		errorCount = 0;
		checkCount = 0;
		modelPlayerId = 1;
		modelFlipper = 1'b0;
		modelScreen = SCREEN_WELCOME;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge clk);
		resetN <= 1'b1;
		repeat (3) @(posedge clk);
		checkSetup("reset values");

		for (i = 0; i < MAX_PLAYERS + 1; i++) begin
			pressKey(KEY_8); // the last presses run into the upper limit
			checkSetup("step up");
		end
		for (i = 0; i < MAX_PLAYERS + 1; i++) begin
			pressKey(KEY_2);
			checkSetup("step down");
		end
		for (i = 0; i < RANDOM_PRESSES; i++) begin
			pick = int'($urandom % 4);
			case (pick)
				0: pressKey(KEY_2);
				1: pressKey(KEY_4);
				2: pressKey(KEY_6);
				default: pressKey(KEY_8);
			endcase
			checkSetup("random press");
		end

		pressKey(KEY_6);
		checkSetup("dual flipper");
		pressKey(KEY_4);
		checkSetup("single flipper");

		for (i = 0; i < MAX_PLAYERS && modelPlayerId > 1; i++) begin
			pressKey(KEY_2);
		end
		checkSetup("hold start");
		startId = modelPlayerId;
		holdKey(KEY_8, HOLD_CYCLES);
		repeat (2 * CLOCKS_PER_SEC) @(posedge clk);
		@(negedge clk);
		stepCount = int'(setup.playerId) - startId;
		maxSteps = (HOLD_CYCLES + CLOCKS_PER_SEC - 1) / CLOCKS_PER_SEC + 1;
		checkCount++;
		assert (stepCount >= 2) else begin
			errorCount++;
			$display("held key 8 stepped playerId only %0d times", stepCount);
		end
		checkCount++;
		assert (stepCount <= maxSteps) else begin
			errorCount++;
			$display("held key 8 stepped playerId %0d times, more than %0d", stepCount,
				maxSteps);
		end
		modelPlayerId = MAX_PLAYERS; // the presses below bring any id down to 1
		for (i = 0; i < MAX_PLAYERS; i++) begin
			pressKey(KEY_2);
		end
		checkSetup("after hold");

		pressKey(KEY_8);
		pressKey(KEY_6);
		pressKey(KEY_5);
		waitForScreen(SCREEN_PLAYING, 2 * CLOCKS_PER_SEC, "start game");
		checkSetup("playing");
		frozenKeys = '{KEY_8, KEY_2, KEY_4, KEY_6, KEY_5};
		foreach (frozenKeys[k]) begin
			pressKey(frozenKeys[k]);
			checkSetup("frozen while playing");
		end

		pulseGameOver();
		modelScreen = SCREEN_GAMEOVER;
		waitForScreen(SCREEN_GAMEOVER, 4, "game over");
		waitForScreen(SCREEN_WELCOME, (GAME_OVER_SECONDS + 1) * CLOCKS_PER_SEC,
			"back to welcome");
		modelScreen = SCREEN_WELCOME;
		checkSetup("setup kept");

		pulseGameOver(); // must be ignored on the welcome screen
		offWelcomeCycles = 0;
		for (i = 0; i < 2 * CLOCKS_PER_SEC; i++) begin
			@(negedge clk);
			if (screen != SCREEN_WELCOME) offWelcomeCycles++;
		end
		checkValue("gameOver on welcome, cycles off welcome", 0, offWelcomeCycles);
		checkSetup("after ignored gameOver");

		$display("checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
source/pinballPkg.sv
source/keypadDecoder.sv
source/secondTimer.sv
source/screenSequencer.sv
source/welcomeController.sv
source/pinballSetupTop.sv
testbench/pinballSetupTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= pinballSetupTb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG_FILE ?= sim.log
PASS_MESSAGE ?= NO ERRORS
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

# the run passes only when the pass message stands on a line of its own in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG_FILE) 2>&1; cat $(LOG_FILE)
	grep -q "^$(PASS_MESSAGE)$$" $(LOG_FILE)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
